// ==== source/systolic_pkg.sv ====
`default_nettype none

package systolic_pkg;

  //////////////////////////////
  // array shape
  //////////////////////////////
  localparam int ROWS      = 2;
  localparam int COLS      = 2;
  localparam int NUM_CELLS = ROWS * COLS;

  // feed lanes
  localparam int PIX_W     = 8;
  localparam int PIX_LANES = 2;   // pixels per column word
  localparam int PIX44_W   = 4;   // low nibble of a lane in mode 1

  //////////////////////////////
  // dsp operands and fields
  //////////////////////////////
  localparam int A_W    = 25;         // column operand
  localparam int B_W    = 18;         // row operand
  localparam int PROD_W = A_W + B_W;
  localparam int F88_W  = 16;         // product field spacing, mode 0
  localparam int F44_W  = 9;          // product field spacing, mode 1

  // accumulators, cell word
  // mode 0: [23:0] pixel0*w, [47:24] pixel1*w, [63:48] zero
  // mode 1: lane k at [16k +: 16] holds pixel(k/2) * weight(k%2),
  //         weight 0 is lane bits [3:0], weight 1 is bits [7:4]
  localparam int ACC88_W    = 24;
  localparam int ACC18_W    = 16;
  localparam int CELL_OUT_W = 4 * ACC18_W;

  typedef logic [3:0] mode_t;
  localparam mode_t MODE_88 = 4'd0;
  localparam mode_t MODE_44 = 4'd1;

  //////////////////////////////
  // result side
  //////////////////////////////
  localparam int RESULT_CREDITS = 2;
  localparam int CREDIT_W       = $clog2(RESULT_CREDITS + 1);
  localparam int CELL_IDX_W     = 2;
  localparam int DRAIN_WAIT     = ROWS + COLS - 1;  // block end to last cell settled
  localparam int WAIT_W         = $clog2(DRAIN_WAIT + 1);

endpackage

`default_nettype wire

// ==== source/pe_ctrl_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// control bundle handed from one cell to the next
interface pe_ctrl_if
  import systolic_pkg::*;
();

  mode_t mode;
  logic  en;     // accumulate this step
  logic  clear;  // zero accumulators, first step of a block
  logic  shift;  // move the drain chain one cell

  modport up_side (
    output mode,
    output en,
    output clear,
    output shift
  );

  modport down_side (
    input mode,
    input en,
    input clear,
    input shift
  );

endinterface

`default_nettype wire

// ==== source/operand_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_decode
  import systolic_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   reset_out,
  input  logic                                   feed_valid,
  input  logic                                   feed_first,
  input  logic                                   feed_last,
  input  mode_t                                  feed_mode,
  input  logic [ROWS-1:0][PIX_W-1:0]             feed_weight,
  input  logic [COLS-1:0][PIX_LANES-1:0][PIX_W-1:0] feed_pixel,
  input  logic                                   busy_in,
  output logic [ROWS-1:0][B_W-1:0]               row_b,
  output logic [COLS-1:0][A_W-1:0]               col_a,
  pe_ctrl_if.up_side                             ctrl,
  output logic                                   drain_start
);

  // two pixels into the 25 bit port, sign carried by the sum
  function automatic logic [A_W-1:0] pack_a(input mode_t m, input logic [PIX_W-1:0] p0,
                                            input logic [PIX_W-1:0] p1);
    logic [A_W-1:0] lo;
    logic [A_W-1:0] hi;
    lo = '0;
    hi = '0;
    if (m == MODE_88) begin
      lo = {{(A_W-PIX_W){p0[PIX_W-1]}}, p0};
      hi = {{(A_W-PIX_W){p1[PIX_W-1]}}, p1} << F88_W;
    end else if (m == MODE_44) begin
      lo = {{(A_W-PIX44_W){p0[PIX44_W-1]}}, p0[PIX44_W-1:0]};
      hi = {{(A_W-PIX44_W){p1[PIX44_W-1]}}, p1[PIX44_W-1:0]} << (2 * F44_W);
    end
    return lo + hi;
  endfunction

  // one weight (mode 0) or two nibbles 9 bits apart (mode 1)
  function automatic logic [B_W-1:0] pack_b(input mode_t m, input logic [PIX_W-1:0] w);
    logic [B_W-1:0] lo;
    logic [B_W-1:0] hi;
    lo = '0;
    hi = '0;
    if (m == MODE_88) begin
      lo = {{(B_W-PIX_W){w[PIX_W-1]}}, w};
    end else if (m == MODE_44) begin
      lo = {{(B_W-PIX44_W){w[PIX44_W-1]}}, w[PIX44_W-1:0]};
      hi = {{(B_W-PIX44_W){w[PIX_W-1]}}, w[PIX_W-1:PIX44_W]} << F44_W;
    end
    return lo + hi;
  endfunction

  logic           accept;
  logic           mode_ok;
  mode_t          step_mode;
  mode_t          mode_q;     // latched on feed_first
  mode_t          ctl_mode_q;
  logic           en_q;
  logic           clear_q;
  logic [B_W-1:0] skew_b;     // row 1 one cycle behind
  logic [A_W-1:0] skew_a;     // column 1 one cycle behind

  assign accept    = feed_valid & ~busy_in;
  assign step_mode = feed_first ? feed_mode : mode_q;
  assign mode_ok   = (step_mode == MODE_88) || (step_mode == MODE_44);

  always_ff @(posedge clk) begin
    if (reset_out) begin
      mode_q      <= MODE_88;
      ctl_mode_q  <= MODE_88;
      en_q        <= 1'b0;
      clear_q     <= 1'b0;
      drain_start <= 1'b0;
    end else begin
      if (accept && feed_first) mode_q <= feed_mode;
      ctl_mode_q  <= step_mode;
      en_q        <= accept & mode_ok;  // unknown codes never accumulate
      clear_q     <= accept & feed_first;
      drain_start <= accept & feed_last;
    end
  end

  assign ctrl.mode  = ctl_mode_q;
  assign ctrl.en    = en_q;
  assign ctrl.clear = clear_q;
  assign ctrl.shift = 1'b0;  // array merges the drain's shift

  always_ff @(posedge clk) begin
    row_b[0] <= pack_b(step_mode, feed_weight[0]);
    skew_b   <= pack_b(step_mode, feed_weight[1]);
    row_b[1] <= skew_b;
    col_a[0] <= pack_a(step_mode, feed_pixel[0][0], feed_pixel[0][1]);
    skew_a   <= pack_a(step_mode, feed_pixel[1][0], feed_pixel[1][1]);
    col_a[1] <= skew_a;
  end

endmodule

`default_nettype wire

// ==== source/pe_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

module pe_cell
  import systolic_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_out,
  pe_ctrl_if.down_side          ctrl_in,
  pe_ctrl_if.up_side            ctrl_out,
  input  logic [B_W-1:0]        left,
  input  logic [A_W-1:0]        up,
  output logic [B_W-1:0]        right,
  output logic [A_W-1:0]        bottom,
  input  logic [CELL_OUT_W-1:0] next_cell_out,
  output logic [CELL_OUT_W-1:0] out
);

  localparam int LANES_44 = CELL_OUT_W / ACC18_W;

  mode_t                     mode_q;
  logic                      en_q;
  logic                      clear_q;
  logic                      shift_q;
  logic signed [PROD_W-1:0]  prod;   // lines up with the registered control
  logic [CELL_OUT_W-1:0]     base;
  logic [ACC88_W-1:0]        f88_lo;
  logic [ACC88_W-1:0]        f88_hi;
  logic [LANES_44-1:0]       borrow;
  logic [ACC18_W-1:0]        f44 [LANES_44];

  always_ff @(posedge clk) begin
    if (reset_out) begin
      mode_q  <= MODE_88;
      en_q    <= 1'b0;
      clear_q <= 1'b0;
      shift_q <= 1'b0;
    end else begin
      mode_q  <= ctrl_in.mode;
      en_q    <= ctrl_in.en;
      clear_q <= ctrl_in.clear;
      shift_q <= ctrl_in.shift;
    end
  end

  assign ctrl_out.mode  = mode_q;
  assign ctrl_out.en    = en_q;
  assign ctrl_out.clear = clear_q;
  assign ctrl_out.shift = shift_q;

  always_ff @(posedge clk) begin
    if (ctrl_in.en) begin
      right  <= left;
      bottom <= up;
    end
    prod <= $signed(up) * $signed(left);  // s25 x s18
  end

  //////////////////////////////
  // split the packed product
  //////////////////////////////
  assign f88_lo = {{(ACC88_W-F88_W){prod[F88_W-1]}}, prod[F88_W-1:0]};
  assign f88_hi = {{(ACC88_W-F88_W){prod[2*F88_W-1]}}, prod[2*F88_W-1:F88_W]}
                  + ACC88_W'(prod[F88_W-1]);  // low field negative took a borrow

  assign borrow = {prod[3*F44_W-1], prod[2*F44_W-1], prod[F44_W-1], 1'b0};

  always_comb begin
    for (int i = 0; i < LANES_44; i++) begin
      f44[i] = {{(ACC18_W-F44_W){prod[F44_W*i+F44_W-1]}}, prod[F44_W*i +: F44_W]}
               + ACC18_W'(borrow[i]);
    end
  end

  assign base = clear_q ? '0 : out;  // first step of a block starts from zero

  always_ff @(posedge clk) begin
    if (en_q) begin
      if (mode_q == MODE_88) begin
        out[0 +: ACC88_W]               <= base[0 +: ACC88_W] + f88_lo;
        out[ACC88_W +: ACC88_W]         <= base[ACC88_W +: ACC88_W] + f88_hi;
        out[CELL_OUT_W-1:2*ACC88_W]     <= base[CELL_OUT_W-1:2*ACC88_W];
      end else if (mode_q == MODE_44) begin
        for (int k = 0; k < LANES_44; k++) begin
          out[k*ACC18_W +: ACC18_W] <= base[k*ACC18_W +: ACC18_W] + f44[k];
        end
      end
    end else if (clear_q) begin
      out <= '0;  // invalid mode block
    end else if (shift_q) begin
      out <= next_cell_out;
    end
  end

endmodule

`default_nettype wire

// ==== source/pe_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module pe_array
  import systolic_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset_out,
  input  logic [ROWS-1:0][B_W-1:0] row_b,
  input  logic [COLS-1:0][A_W-1:0] col_a,
  pe_ctrl_if.down_side            ctrl,
  input  logic                    shift_en,
  output logic [CELL_OUT_W-1:0]   drain_word
);

  logic [B_W-1:0]        left_w   [NUM_CELLS];
  logic [B_W-1:0]        right_w  [NUM_CELLS];
  logic [A_W-1:0]        up_w     [NUM_CELLS];
  logic [A_W-1:0]        bottom_w [NUM_CELLS];
  logic [CELL_OUT_W-1:0] chain_w  [NUM_CELLS];
  logic [CELL_OUT_W-1:0] out_w    [NUM_CELLS];

  pe_ctrl_if tap  [NUM_CELLS] ();  // cell input, shift merged in
  pe_ctrl_if link [NUM_CELLS] ();  // cell output

  // cell k = r*COLS + c, control reaches it after r+c hops
  for (genvar r = 0; r < ROWS; r++) begin : g_row
    for (genvar c = 0; c < COLS; c++) begin : g_col
      localparam int K = r * COLS + c;

      if (K == 0) begin : g_ctl_head
        assign tap[K].mode  = ctrl.mode;
        assign tap[K].en    = ctrl.en;
        assign tap[K].clear = ctrl.clear;
      end else if (c > 0) begin : g_ctl_left
        assign tap[K].mode  = link[K-1].mode;
        assign tap[K].en    = link[K-1].en;
        assign tap[K].clear = link[K-1].clear;
      end else begin : g_ctl_up
        assign tap[K].mode  = link[K-COLS].mode;
        assign tap[K].en    = link[K-COLS].en;
        assign tap[K].clear = link[K-COLS].clear;
      end
      assign tap[K].shift = shift_en;  // all cells shift on the same edge

      if (c == 0) begin : g_b_edge
        assign left_w[K] = row_b[r];
      end else begin : g_b_pass
        assign left_w[K] = right_w[K-1];
      end

      if (r == 0) begin : g_a_edge
        assign up_w[K] = col_a[c];
      end else begin : g_a_pass
        assign up_w[K] = bottom_w[K-COLS];
      end

      // drain chain runs 3, 2, 1, 0 toward the output
      if (K == 0) begin : g_chain_head
        assign chain_w[K] = '0;
      end else begin : g_chain_link
        assign chain_w[K] = out_w[K-1];
      end

      pe_cell cell_inst (
        .clk           (clk),
        .reset_out     (reset_out),
        .ctrl_in       (tap[K]),
        .ctrl_out      (link[K]),
        .left          (left_w[K]),
        .up            (up_w[K]),
        .right         (right_w[K]),
        .bottom        (bottom_w[K]),
        .next_cell_out (chain_w[K]),
        .out           (out_w[K])
      );
    end
  end

  assign drain_word = out_w[NUM_CELLS-1];

endmodule

`default_nettype wire

// ==== source/result_drain.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_drain
  import systolic_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset_out,
  input  logic                  drain_start,
  input  logic [CELL_OUT_W-1:0] drain_word,
  output logic                  shift_en,
  output logic                  busy,
  output logic                  result_valid,
  output logic [CELL_OUT_W-1:0] result_data,
  output logic [CELL_IDX_W-1:0] result_cell,
  input  logic                  credit_return
);

  localparam logic [CELL_IDX_W-1:0] LAST_CELL = CELL_IDX_W'(NUM_CELLS - 1);

  logic                  active;    // block ended, results pending
  logic                  gap;       // chain still moving after a shift
  logic                  send;
  logic [WAIT_W-1:0]     wait_cnt;  // array settling after the last step
  logic [CELL_IDX_W-1:0] cell_idx;
  logic [CREDIT_W-1:0]   credits;

  // the single credit check, one shift per result
  assign send     = active & ~gap & (wait_cnt == '0) & (credits != '0);
  assign shift_en = send;
  assign busy     = active | drain_start;

  //////////////////////////////
  // control
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset_out) begin
      active       <= 1'b0;
      gap          <= 1'b0;
      wait_cnt     <= '0;
      cell_idx     <= LAST_CELL;
      credits      <= CREDIT_W'(RESULT_CREDITS);
      result_valid <= 1'b0;
    end else begin
      result_valid <= send;
      gap          <= send;  // new word shows two cycles after shift_en
      credits      <= credits - CREDIT_W'(result_valid) + CREDIT_W'(credit_return);
      if (drain_start) begin
        active   <= 1'b1;
        wait_cnt <= WAIT_W'(DRAIN_WAIT);
        cell_idx <= LAST_CELL;
      end else begin
        if (wait_cnt != '0) wait_cnt <= wait_cnt - 1'b1;
        if (send) begin
          cell_idx <= cell_idx - 1'b1;
          if (cell_idx == '0) active <= 1'b0;  // fourth result out
        end
      end
    end
  end

  // result word holds while no credit is left
  always_ff @(posedge clk) begin
    if (send) begin
      result_data <= drain_word;
      result_cell <= cell_idx;
    end
  end

endmodule

`default_nettype wire

// ==== source/systolic_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_top
  import systolic_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   reset_out,
  input  logic                                   feed_valid,
  input  logic                                   feed_first,
  input  logic                                   feed_last,
  input  mode_t                                  feed_mode,
  input  logic [ROWS-1:0][PIX_W-1:0]             feed_weight,
  input  logic [COLS-1:0][PIX_LANES-1:0][PIX_W-1:0] feed_pixel,
  output logic                                   busy,
  output logic                                   result_valid,
  output logic [CELL_OUT_W-1:0]                  result_data,
  output logic [CELL_IDX_W-1:0]                  result_cell,
  input  logic                                   credit_return
);

  logic [ROWS-1:0][B_W-1:0] row_b;
  logic [COLS-1:0][A_W-1:0] col_a;
  logic                     drain_start;
  logic                     shift_en;
  logic [CELL_OUT_W-1:0]    drain_word;

  pe_ctrl_if ctrl_bus ();

  operand_decode decode_inst (
    .clk         (clk),
    .reset_out   (reset_out),
    .feed_valid  (feed_valid),
    .feed_first  (feed_first),
    .feed_last   (feed_last),
    .feed_mode   (feed_mode),
    .feed_weight (feed_weight),
    .feed_pixel  (feed_pixel),
    .busy_in     (busy),
    .row_b       (row_b),
    .col_a       (col_a),
    .ctrl        (ctrl_bus),
    .drain_start (drain_start)
  );

  pe_array array_inst (
    .clk        (clk),
    .reset_out  (reset_out),
    .row_b      (row_b),
    .col_a      (col_a),
    .ctrl       (ctrl_bus),
    .shift_en   (shift_en),
    .drain_word (drain_word)
  );

  result_drain drain_inst (
    .clk           (clk),
    .reset_out     (reset_out),
    .drain_start   (drain_start),
    .drain_word    (drain_word),
    .shift_en      (shift_en),
    .busy          (busy),
    .result_valid  (result_valid),
    .result_data   (result_data),
    .result_cell   (result_cell),
    .credit_return (credit_return)
  );

endmodule

`default_nettype wire

// ==== test/systolic_top_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_top_sva
  import systolic_pkg::*;
(
  input logic                  clk,
  input logic                  reset_out,
  input logic                  feed_valid,
  input logic                  busy,
  input logic                  result_valid,
  input logic [CELL_OUT_W-1:0] result_data,
  input logic                  credit_return
);

  logic [CREDIT_W-1:0] credit_cnt;  // consumer side view of the credits

  always_ff @(posedge clk) begin
    if (reset_out) begin
      credit_cnt <= CREDIT_W'(RESULT_CREDITS);
    end else begin
      credit_cnt <= credit_cnt - CREDIT_W'(result_valid) + CREDIT_W'(credit_return);
    end
  end

  a_valid_has_credit : assert property (@(posedge clk) disable iff (reset_out)
    result_valid |-> credit_cnt != '0)
    else $error("result_valid raised with no credit left");

  a_no_feed_when_busy : assert property (@(posedge clk) disable iff (reset_out)
    busy |-> !feed_valid)
    else $error("feed_valid driven while busy");

  a_data_holds : assert property (@(posedge clk) disable iff (reset_out)
    credit_cnt == '0 |=> $stable(result_data))
    else $error("result_data moved while out of credits");

endmodule

bind systolic_top systolic_top_sva sva_inst (
  .clk           (clk),
  .reset_out     (reset_out),
  .feed_valid    (feed_valid),
  .busy          (busy),
  .result_valid  (result_valid),
  .result_data   (result_data),
  .credit_return (credit_return)
);

`default_nettype wire

// ==== test/systolic_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module systolic_top_tb
  import systolic_pkg::*;
();

  localparam int HOLD_CYCLES = 40;   // credit returns withheld this long
  localparam int DRAIN_LIMIT = 400;
  localparam int IDLE_LIMIT  = 50;
  localparam int QUIET_CYCLES = 20;

  logic                                      clk;
  logic                                      reset_out;
  logic                                      feed_valid;
  logic                                      feed_first;
  logic                                      feed_last;
  mode_t                                     feed_mode;
  logic [ROWS-1:0][PIX_W-1:0]                feed_weight;
  logic [COLS-1:0][PIX_LANES-1:0][PIX_W-1:0] feed_pixel;
  logic                                      busy;
  logic                                      result_valid;
  logic [CELL_OUT_W-1:0]                     result_data;
  logic [CELL_IDX_W-1:0]                     result_cell;
  logic                                      credit_return;

  logic [CELL_OUT_W-1:0] model_acc [NUM_CELLS];  // reference accumulators
  logic [CELL_OUT_W-1:0] got_word  [NUM_CELLS];  // last block as returned, by cell
  mode_t                 model_mode;
  int                    pending;                // results not yet given back as credit
  bit                    hold_next;

  systolic_top systolic_top_inst (
    .clk           (clk),
    .reset_out     (reset_out),
    .feed_valid    (feed_valid),
    .feed_first    (feed_first),
    .feed_last     (feed_last),
    .feed_mode     (feed_mode),
    .feed_weight   (feed_weight),
    .feed_pixel    (feed_pixel),
    .busy          (busy),
    .result_valid  (result_valid),
    .result_data   (result_data),
    .result_cell   (result_cell),
    .credit_return (credit_return)
  );

  always #10 clk = ~clk;

  task automatic abort_run();
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
    end
  endtask

  function automatic int sx8(input logic [7:0] v);
    return int'($signed(v));
  endfunction

  function automatic int sx4(input logic [3:0] v);
    return int'($signed(v));
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////
  task automatic model_step(input logic first, input mode_t mode,
                            input logic [ROWS-1:0][PIX_W-1:0] w,
                            input logic [COLS-1:0][PIX_LANES-1:0][PIX_W-1:0] p);
    int k;
    if (first) begin
      model_mode = mode;  // block mode, later steps ignore feed_mode
      for (k = 0; k < NUM_CELLS; k++) model_acc[k] = '0;
    end
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        k = r * COLS + c;
        if (model_mode == MODE_88) begin
          model_acc[k][0 +: ACC88_W] = model_acc[k][0 +: ACC88_W]
                                       + ACC88_W'(sx8(p[c][0]) * sx8(w[r]));
          model_acc[k][ACC88_W +: ACC88_W] = model_acc[k][ACC88_W +: ACC88_W]
                                             + ACC88_W'(sx8(p[c][1]) * sx8(w[r]));
        end else if (model_mode == MODE_44) begin
          // lane l is pixel l/2 times weight nibble l%2
          for (int l = 0; l < 4; l++) begin
            model_acc[k][ACC18_W*l +: ACC18_W] = model_acc[k][ACC18_W*l +: ACC18_W]
              + ACC18_W'(sx4(p[c][l/2][3:0]) * sx4(w[r][4*(l%2) +: 4]));
          end
        end
      end
    end
  endtask

  //////////////////////////////
  // feed side
  //////////////////////////////
  task automatic wait_idle();
    int n;
    n = 0;
    @(negedge clk);
    while (busy) begin
      n++;
      if (n > IDLE_LIMIT) begin
        $display("timeout: busy stayed high before a feed step");
        abort_run();
      end
      @(negedge clk);
    end
  endtask

  task automatic feed_step(input logic first, input logic last, input mode_t mode,
                           input logic [ROWS-1:0][PIX_W-1:0] w,
                           input logic [COLS-1:0][PIX_LANES-1:0][PIX_W-1:0] p);
    wait_idle();
    @(posedge clk);
    feed_valid  <= 1'b1;
    feed_first  <= first;
    feed_last   <= last;
    feed_mode   <= mode;
    feed_weight <= w;
    feed_pixel  <= p;
    @(posedge clk);
    feed_valid <= 1'b0;
    feed_first <= 1'b0;
    feed_last  <= 1'b0;
    model_step(first, mode, w, p);
  endtask

  //////////////////////////////
  // result side
  //////////////////////////////
  task automatic drain_block(input bit hold);
    int seen;
    int cycles;
    bit ret;
    seen   = 0;
    cycles = 0;
    while (seen < NUM_CELLS) begin
      @(negedge clk);
      cycles++;
      if (cycles > DRAIN_LIMIT) begin
        $display("timeout: block results did not all arrive");
        abort_run();
      end
      if (result_valid) begin
        check_value("result_cell", result_cell, NUM_CELLS - 1 - seen);  // 3, 2, 1, 0
        check_value("result_data", result_data, model_acc[NUM_CELLS - 1 - seen]);
        got_word[result_cell] = result_data;
        seen++;
        pending++;
        if (hold && cycles <= HOLD_CYCLES && seen > RESULT_CREDITS) begin
          $display("more results came out than credits while returns were withheld");
          abort_run();
        end
      end
      if (seen == NUM_CELLS)
        check_value("busy", busy, 1'b0);
      else
        check_value("busy", busy, 1'b1);  // high until the fourth result
      if (hold && cycles == HOLD_CYCLES) check_value("result count", seen, RESULT_CREDITS);
      ret = (pending > 0) && !(hold && cycles < HOLD_CYCLES) && (($urandom % 3) != 0);
      @(posedge clk);
      credit_return <= ret;
      if (ret) pending--;
    end
    while (pending > 0) begin  // hand back the rest so the next block starts full
      @(posedge clk);
      credit_return <= 1'b1;
      pending--;
    end
    @(posedge clk);
    credit_return <= 1'b0;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    reset_out     <= 1'b1;
    feed_valid    <= 1'b0;
    credit_return <= 1'b0;
    repeat (8) @(posedge clk);
    reset_out <= 1'b0;
    pending = 0;
  endtask

  task automatic check_quiet();
    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_value("busy", busy, 1'b0);
      check_value("result_valid", result_valid, 1'b0);
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          kind;
    int          blocks;
    string       line;
    logic [63:0] f [9];
    void'($urandom(32'h271a1cf2));
    clk           = 1'b0;
    reset_out     = 1'b1;
    feed_valid    = 1'b0;
    feed_first    = 1'b0;
    feed_last     = 1'b0;
    feed_mode     = MODE_88;
    feed_weight   = '0;
    feed_pixel    = '0;
    credit_return = 1'b0;
    pending       = 0;
    hold_next     = 1'b0;
    blocks        = 0;
    repeat (8) @(posedge clk);
    reset_out <= 1'b0;

    fd = $fopen("test/systolic_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open test/systolic_tests.txt");
      abort_run();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", kind,
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
      case (kind)
        1: begin
          if (n != 10) begin
            $display("malformed step line in test file");
            abort_run();
          end
          feed_step(f[0][0], f[1][0], mode_t'(f[2][3:0]), {f[4][7:0], f[3][7:0]},
                    {f[8][7:0], f[7][7:0], f[6][7:0], f[5][7:0]});
          if (f[1][0]) begin
            drain_block(hold_next);
            hold_next = 1'b0;
            blocks++;
          end
        end
        2: check_value("result_data", got_word[f[0][1:0]], f[1]);
        3: hold_next = 1'b1;
        4: begin
          apply_reset();
          check_quiet();
        end
        default: begin
          $display("unknown line kind %0d in test file", kind);
          abort_run();
        end
      endcase
    end
    $fclose(fd);
    if (blocks == 0) begin
      $display("test file held no complete block");
      abort_run();
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== test/systolic_tests.txt ====
# 1 = step: first last mode w0 w1 p00 p01 p10 p11 (hex)   2 = expected: cell word
# 3 = withhold credits during the next drain              4 = reset in mid-block
1 1 1 0 03 FE 05 FB 7F 80
2 0 0000FFFFF100000F
2 1 0000FFFE8000017D
2 2 000000000AFFFFF6
2 3 0000000100FFFF02
1 1 0 0 80 81 80 7F 81 FF
1 0 0 0 7F 80 80 80 7F 7F
1 0 1 0 FF 01 01 FF 80 80
1 1 0 1 2F 9C 53 C9 A7 18
1 0 1 1 71 E5 3E 84 6F F2
2 0 000E000BFFF8FFFB
3
1 1 0 0 11 EE 22 DD 33 CC
1 0 1 0 F0 0F 44 BB 55 AA
1 1 1 0 03 FE 05 FB 7F 80
2 3 0000000100FFFF02
1 1 0 2 12 34 56 78 9A BC
1 0 1 2 55 66 77 88 99 AA
2 0 0000000000000000
2 3 0000000000000000
1 1 0 1 77 88 99 AA BB CC
1 0 0 1 12 34 56 78 9A BC
4
1 1 0 0 40 C0 02 FE 10 F0
1 0 1 0 09 F7 03 FD 7E 82

// ==== systolic_top.f ====
source/systolic_pkg.sv
source/pe_ctrl_if.sv
source/operand_decode.sv
source/pe_cell.sv
source/pe_array.sv
source/result_drain.sv
source/systolic_top.sv
test/systolic_top_sva.sv
test/systolic_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module systolic_top_tb \
  -f systolic_top.f
./obj_dir/Vsystolic_top_tb
